// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= soc_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bios.hex
// One 16-bit ROM word per line, word addresses 0 to 15
EA5B
00F0
FA31
C08E
D08E
BC00
7CFB
B800
B08E
D833
FF31
F6C3
9090
A5A5
5A5A
C3F4

// File: bios_rom.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module bios_rom (
    input  logic                clk,
    input  logic                rst,
    input  logic                sel,
    input  soc_pkg::word_addr_t addr,
    output soc_pkg::data_t      rdata,
    output logic                ack
);
    import soc_pkg::*;

    localparam int AW = $clog2(`BIOS_WORDS);

    data_t rom [`BIOS_WORDS];
    data_t rd_q;

    initial $readmemh("bios.hex", rom);

    always_ff @(posedge clk) begin
        if (sel) begin
            rd_q <= rom[addr[AW:1]];    // Wraps within the ROM
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= sel && !ack;         // Writes are acked but dropped
        end
    end

    assign rdata = ack ? rd_q : '0;

endmodule

`default_nettype wire

// File: build.f
+incdir+.
soc_pkg.sv
mem_arbiter.sv
bus_decoder.sv
bios_rom.sv
ram.sv
timer.sv
irq_controller.sv
soc_top.sv
soc_checker.sv
soc_tb.sv

// File: bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module bus_decoder (
    input  logic               clk,
    input  logic               rst,
    input  logic               data_access,
    input  soc_pkg::data_req_t data_req,
    output logic               io_ack,
    output soc_pkg::data_t     io_rdata,
    output logic               timer_sel,
    output logic               irq_sel,
    output logic               ram_sel,
    output logic               bios_sel,
    input  soc_pkg::data_t     timer_rdata,
    input  soc_pkg::data_t     irq_rdata,
    input  soc_pkg::data_t     ram_rdata,
    input  soc_pkg::data_t     bios_rdata,
    input  logic               timer_ack,
    input  logic               irq_ack,
    input  logic               ram_ack,
    input  logic               bios_ack,
    input  logic               q_access,
    input  soc_pkg::mem_req_t  q_req,
    output logic               q_ack,
    output soc_pkg::data_t     q_rdata
);
    import soc_pkg::*;

    port_t port;
    data_t bios_ctrl_rdata;
    logic  io_access;
    logic  bios_ctrl_sel;
    logic  bios_ctrl_ack;
    logic  default_sel;
    logic  default_ack;
    logic  bios_enabled;
    logic  bios_window;

    assign io_access = data_access && data_req.io;
    assign port      = {data_req.req.addr[15:1], 1'b0};

    always_comb begin
        timer_sel     = 1'b0;
        irq_sel       = 1'b0;
        bios_ctrl_sel = 1'b0;
        default_sel   = 1'b0;
        if (io_access) begin
            case (port)
                `PORT_TIMER:                   timer_sel     = 1'b1;
                `PORT_IRQ_MASK, `PORT_IRQ_PEND: irq_sel       = 1'b1;
                `PORT_BIOS_CTRL:               bios_ctrl_sel = 1'b1;
                default:                       default_sel   = 1'b1; // Unclaimed port
            endcase
        end
    end

    // Boot window only while the ROM is mapped in
    assign bios_window = bios_enabled && (q_req.addr[19:13] == `BIOS_BASE_HI);
    assign bios_sel    = q_access && bios_window;
    assign ram_sel     = q_access && !bios_window;

    always_ff @(posedge clk) begin
        if (rst) begin
            bios_ctrl_ack <= 1'b0;
            default_ack   <= 1'b0;
            bios_enabled  <= 1'b1;
        end else begin
            bios_ctrl_ack <= bios_ctrl_sel && !bios_ctrl_ack;
            default_ack   <= default_sel && !default_ack;
            if (bios_ctrl_sel && !bios_ctrl_ack && data_req.req.wr_en &&
                data_req.req.bytesel[0]) begin
                bios_enabled <= data_req.req.wdata[0];
            end
        end
    end

    assign bios_ctrl_rdata = bios_ctrl_ack ? {15'b0, bios_enabled} : '0;

    assign io_ack   = timer_ack | irq_ack | bios_ctrl_ack | default_ack;
    assign io_rdata = timer_rdata | irq_rdata | bios_ctrl_rdata; // Default port reads zero
    assign q_ack    = ram_ack | bios_ack;
    assign q_rdata  = ram_rdata | bios_rdata;

endmodule

`default_nettype wire

// File: irq_controller.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module irq_controller (
    input  logic               clk,
    input  logic               rst,
    input  logic               sel,
    input  soc_pkg::data_req_t req,
    input  soc_pkg::irq_vec_t  irq_in,
    output soc_pkg::data_t     rdata,
    output logic               ack,
    output logic               intr
);
    import soc_pkg::*;

    port_t    port;
    irq_vec_t mask;
    irq_vec_t pending;
    irq_vec_t irq_prev;
    irq_vec_t clr_bits;
    data_t    rd_q;
    logic     wr_stb;
    logic     is_pend;

    assign port    = {req.req.addr[15:1], 1'b0};
    assign is_pend = (port == `PORT_IRQ_PEND);
    assign wr_stb  = sel && !ack && req.req.wr_en && req.req.bytesel[0];
    assign clr_bits = (wr_stb && is_pend) ? req.req.wdata[7:0] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack      <= 1'b0;
            mask     <= '1;
            pending  <= '0;
            irq_prev <= '0;
            intr     <= 1'b0;
        end else begin
            ack      <= sel && !ack;
            irq_prev <= irq_in;
            pending  <= (pending & ~clr_bits) | (irq_in & ~irq_prev); // New edge wins
            if (wr_stb && !is_pend) begin
                mask <= req.req.wdata[7:0];
            end
            intr <= |(pending & ~mask);
        end
    end

    always_ff @(posedge clk) begin
        if (sel && !ack) begin
            rd_q <= is_pend ? {8'b0, pending} : {8'b0, mask};
        end
    end

    assign rdata = ack ? rd_q : '0;

endmodule

`default_nettype wire

// File: mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_access,
    input  soc_pkg::word_addr_t instr_addr,
    output logic                instr_ack,
    output soc_pkg::data_t      instr_rdata,
    input  logic                data_access,
    input  soc_pkg::mem_req_t   data_req,
    output logic                data_ack,
    output soc_pkg::data_t      data_rdata,
    output logic                q_access,
    output soc_pkg::mem_req_t   q_req,
    input  logic                q_ack,
    input  soc_pkg::data_t      q_rdata
);
    import soc_pkg::*;

    arb_state_t state;
    logic       last_instr;     // Fetch was served last

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ARB_IDLE;
            last_instr <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (instr_access && data_access) begin
                        state <= last_instr ? ARB_DATA : ARB_INSTR;
                    end else if (instr_access) begin
                        state <= ARB_INSTR;
                    end else if (data_access) begin
                        state <= ARB_DATA;
                    end
                end
                ARB_INSTR: begin
                    if (q_ack) begin
                        state      <= ARB_IDLE;
                        last_instr <= 1'b1;
                    end
                end
                ARB_DATA: begin
                    if (q_ack) begin
                        state      <= ARB_IDLE;
                        last_instr <= 1'b0;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    assign q_access = (state != ARB_IDLE);

    // Fetches are always full-word reads
    assign q_req = (state == ARB_INSTR) ? mem_req_t'{addr: instr_addr, wdata: '0, wr_en: 1'b0,
                                                     bytesel: 2'b11}
                                        : data_req;

    assign instr_ack   = q_ack && (state == ARB_INSTR);
    assign data_ack    = q_ack && (state == ARB_DATA);
    assign instr_rdata = instr_ack ? q_rdata : '0;
    assign data_rdata  = data_ack ? q_rdata : '0;

endmodule

`default_nettype wire

// File: ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module ram (
    input  logic              clk,
    input  logic              rst,
    input  logic              sel,
    input  soc_pkg::mem_req_t req,
    output soc_pkg::data_t    rdata,
    output logic              ack
);
    import soc_pkg::*;

    localparam int AW = $clog2(`RAM_WORDS);

    data_t         mem [`RAM_WORDS];
    data_t         rd_q;
    logic [AW-1:0] idx;
    logic          wr_stb;

    assign idx    = req.addr[AW:1];     // Wraps modulo RAM size
    assign wr_stb = sel && !ack && req.wr_en;

    always_ff @(posedge clk) begin
        if (wr_stb && req.bytesel[0]) begin
            mem[idx][7:0] <= req.wdata[7:0];
        end
        if (wr_stb && req.bytesel[1]) begin
            mem[idx][15:8] <= req.wdata[15:8];
        end
        if (sel) begin
            rd_q <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= sel && !ack;
        end
    end

    assign rdata = ack ? rd_q : '0;

endmodule

`default_nettype wire

// File: soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// On-chip memory sizes in 16-bit words
`define RAM_WORDS       256
`define BIOS_WORDS      16

// Byte address bits 19..13 of the boot window 0xFE000 to 0xFFFFF
`define BIOS_BASE_HI    7'b1111111

// I/O port map
`define PORT_TIMER      16'hFFEE
`define PORT_BIOS_CTRL  16'hFFEC
`define PORT_IRQ_MASK   16'hFFF4
`define PORT_IRQ_PEND   16'hFFF6

`endif

// File: soc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module soc_checker (
    input logic clk,
    input logic rst,
    input logic instr_access,
    input logic instr_ack,
    input logic data_access,
    input logic data_ack,
    input logic q_access,
    input logic q_ack,
    input logic intr
);

    a_instr_pulse: assert property (@(posedge clk) disable iff (rst) instr_ack |=> !instr_ack)
        else $error("instr_ack held for more than one cycle");
    a_data_pulse: assert property (@(posedge clk) disable iff (rst) data_ack |=> !data_ack)
        else $error("data_ack held for more than one cycle");
    a_q_pulse: assert property (@(posedge clk) disable iff (rst) q_ack |=> !q_ack)
        else $error("q_ack held for more than one cycle");

    // Ack only inside an open access
    a_instr_open: assert property (@(posedge clk) disable iff (rst) instr_ack |-> instr_access)
        else $error("instr_ack without instr_access");
    a_data_open: assert property (@(posedge clk) disable iff (rst) data_ack |-> data_access)
        else $error("data_ack without data_access");
    a_q_open: assert property (@(posedge clk) disable iff (rst) q_ack |-> q_access)
        else $error("q_ack without q_access");

    a_intr_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(intr))
        else $error("intr is unknown");

endmodule

bind soc_top soc_checker i_soc_checker (
    .clk(clk), .rst(rst),
    .instr_access(instr_access), .instr_ack(instr_ack),
    .data_access(data_access), .data_ack(data_ack),
    .q_access(q_access), .q_ack(q_ack), .intr(intr)
);

`default_nettype wire

// File: soc_pkg.sv
`default_nettype none

package soc_pkg;

    typedef logic [19:1] word_addr_t;   // Byte address without bit 0
    typedef logic [15:0] data_t;
    typedef logic [1:0]  bytesel_t;     // Bit 0 is the low byte
    typedef logic [15:0] port_t;
    typedef logic [7:0]  irq_vec_t;

    typedef struct packed {
        word_addr_t addr;
        data_t      wdata;
        logic       wr_en;
        bytesel_t   bytesel;
    } mem_req_t;

    // Port number is the low 16 bits of the byte address when io is set
    typedef struct packed {
        mem_req_t req;
        logic     io;
    } data_req_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_INSTR,
        ARB_DATA
    } arb_state_t;

endpackage

`default_nettype wire

// File: soc_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module soc_tb;
    import soc_pkg::*;

    localparam int CYCLE_LIMIT = 20000; // Full run takes about 4000 cycles
    localparam int N_RANDOM    = 200;
    localparam int N_CONC      = 60;

    logic       clk;
    logic       rst;
    logic       instr_access;
    word_addr_t instr_addr;
    logic       instr_ack;
    data_t      instr_rdata;
    logic       data_access;
    data_req_t  data_req;
    logic       data_ack;
    data_t      data_rdata;
    logic       intr;

    data_t ram_m [`RAM_WORDS];
    data_t rom_m [`BIOS_WORDS];
    logic  bios_en_m;
    int    cycles = 0;

    soc_top i_soc_top (
        .clk(clk), .rst(rst),
        .instr_access(instr_access), .instr_addr(instr_addr),
        .instr_ack(instr_ack), .instr_rdata(instr_rdata),
        .data_access(data_access), .data_req(data_req),
        .data_ack(data_ack), .data_rdata(data_rdata), .intr(intr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Error: run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic word_ok(input data_t got, input data_t exp, input string what);
        if (got !== exp) mismatch($sformatf("%s read %h, expected %h", what, got, exp));
    endtask

    task automatic vec_ok(input irq_vec_t got, input irq_vec_t exp, input string what);
        if (got !== exp) mismatch($sformatf("%s read %b, expected %b", what, got, exp));
    endtask

    task automatic cycles_ok(input int got, input int exp, input string what);
        if (got != exp) mismatch($sformatf("%s was %0d cycles, expected %0d", what, got, exp));
    endtask

    task automatic level_ok(input logic got, input logic exp, input string what);
        if (got !== exp) mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    function automatic logic in_boot_window(input word_addr_t a);
        return bios_en_m && (a[19:13] == `BIOS_BASE_HI);
    endfunction

    function automatic data_t expected_word(input word_addr_t a);
        if (in_boot_window(a)) return rom_m[int'(a) % `BIOS_WORDS];
        return ram_m[int'(a) % `RAM_WORDS];
    endfunction

    function automatic void record_write(input word_addr_t a, input data_t wd, input bytesel_t bs);
        int idx;
        idx = int'(a) % `RAM_WORDS;
        if (in_boot_window(a)) return; // ROM drops writes
        if (bs[0]) ram_m[idx][7:0] = wd[7:0];
        if (bs[1]) ram_m[idx][15:8] = wd[15:8];
    endfunction

    function automatic logic is_mapped(input port_t p);
        port_t e;
        e = {p[15:1], 1'b0};
        return e == `PORT_TIMER || e == `PORT_BIOS_CTRL ||
               e == `PORT_IRQ_MASK || e == `PORT_IRQ_PEND;
    endfunction

    function automatic data_req_t make_req(input word_addr_t a, input data_t wd, input logic we,
                                           input bytesel_t bs, input logic io);
        data_req_t r;
        r.req.addr    = a;
        r.req.wdata   = wd;
        r.req.wr_en   = we;
        r.req.bytesel = bs;
        r.io          = io;
        return r;
    endfunction

    // Cycles counted from the edge that raises access to the ack cycle
    task automatic data_cycle(input data_req_t req, output data_t rd, output int cyc);
        @(posedge clk);
        data_access <= 1'b1;
        data_req    <= req;
        cyc = 0;
        @(negedge clk);
        while (!data_ack) begin
            cyc++;
            @(negedge clk);
        end
        rd = data_rdata;
        @(posedge clk);
        data_access <= 1'b0;
    endtask

    task automatic fetch_cycle(input word_addr_t a, output data_t rd, output int cyc);
        @(posedge clk);
        instr_access <= 1'b1;
        instr_addr   <= a;
        cyc = 0;
        @(negedge clk);
        while (!instr_ack) begin
            cyc++;
            @(negedge clk);
        end
        rd = instr_rdata;
        @(posedge clk);
        instr_access <= 1'b0;
    endtask

    task automatic io_access(input port_t p, input logic we, input data_t wd, output data_t rd);
        int cyc;
        data_cycle(make_req({4'b0, p[15:1]}, wd, we, 2'b11, 1'b1), rd, cyc);
        cycles_ok(cyc, 1, $sformatf("I/O ack at port %h", p));
    endtask

    task automatic mem_access(input word_addr_t a, input logic we, input data_t wd,
                              input bytesel_t bs, input logic timed);
        data_t rd;
        data_t exp;
        int    cyc;
        exp = expected_word(a);
        data_cycle(make_req(a, wd, we, bs, 1'b0), rd, cyc);
        if (we) record_write(a, wd, bs);
        else word_ok(rd, exp, $sformatf("Data read at %h", a));
        if (timed) cycles_ok(cyc, 2, "Uncontended memory ack");
    endtask

    task automatic fetch_check(input word_addr_t a, input logic timed);
        data_t rd;
        int    cyc;
        fetch_cycle(a, rd, cyc);
        word_ok(rd, expected_word(a), $sformatf("Fetch at %h", a));
        if (timed) cycles_ok(cyc, 2, "Uncontended fetch ack");
    endtask

    task automatic intr_within(input int start, input int limit, input string what);
        @(negedge clk);
        while (!intr) begin
            if (cycles - start > limit) begin
                $display("Error: intr did not rise within %0d cycles %s", limit, what);
                stop_run();
            end
            @(negedge clk);
        end
    endtask

    initial begin
        word_addr_t a;
        word_addr_t win_addr [`BIOS_WORDS];
        data_t      rd;
        port_t      p;
        int         n;
        int         start;

        instr_access = 1'b0;
        instr_addr   = '0;
        data_access  = 1'b0;
        data_req     = '0;
        rst          = 1'b1;
        void'($urandom(69));
        $readmemh("bios.hex", rom_m);
        bios_en_m = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // 1: RAM preload, then random reads and writes across the whole space
        for (int i = 0; i < `RAM_WORDS; i++) begin
            mem_access(word_addr_t'(i), 1'b1, data_t'($urandom), 2'b11, 1'b1);
        end
        repeat (N_RANDOM) begin
            mem_access(word_addr_t'($urandom), 1'($urandom), data_t'($urandom),
                       bytesel_t'($urandom), 1'b1);
        end
        repeat (8) begin
            a = word_addr_t'($urandom);
            a[19] = 1'b0;
            mem_access(a, 1'b1, data_t'($urandom), 2'b11, 1'b1);
            mem_access(a + word_addr_t'(`RAM_WORDS), 1'b0, '0, 2'b11, 1'b1); // Alias
        end

        // 2: both masters at once on separate RAM halves
        fork
            begin : fetch_master
                word_addr_t fa;
                repeat (N_CONC) begin
                    fa = word_addr_t'($urandom);
                    fa[8] = 1'b0;
                    fetch_check(fa, 1'b0);
                    repeat ($urandom_range(2, 0)) @(posedge clk);
                end
            end
            begin : data_master
                word_addr_t da;
                repeat (N_CONC) begin
                    da = word_addr_t'($urandom);
                    da[8] = 1'b1;
                    mem_access(da, 1'($urandom), data_t'($urandom), bytesel_t'($urandom), 1'b0);
                    repeat ($urandom_range(2, 0)) @(posedge clk);
                end
            end
        join

        // 3: boot window mapped in, then out, then back in
        io_access(`PORT_BIOS_CTRL, 1'b0, '0, rd);
        word_ok(rd, 16'h0001, "BIOS control after reset");
        for (int i = 0; i < `BIOS_WORDS; i++) begin
            win_addr[i] = {`BIOS_BASE_HI, 8'($urandom), 4'(i)};
            fetch_check(win_addr[i], 1'b1);
        end
        io_access(`PORT_BIOS_CTRL, 1'b1, 16'h0000, rd);
        bios_en_m = 1'b0;
        io_access(`PORT_BIOS_CTRL, 1'b0, '0, rd);
        word_ok(rd, 16'h0000, "BIOS control after disable");
        for (int i = 0; i < `BIOS_WORDS; i++) fetch_check(win_addr[i], 1'b1);
        io_access(`PORT_BIOS_CTRL, 1'b1, 16'h0001, rd);
        bios_en_m = 1'b1;
        io_access(`PORT_BIOS_CTRL, 1'b0, '0, rd);
        word_ok(rd, 16'h0001, "BIOS control after enable");

        // 4: unclaimed ports
        repeat (20) begin
            do p = port_t'($urandom); while (is_mapped(p));
            io_access(p, 1'($urandom), data_t'($urandom), rd);
            word_ok(rd, 16'h0000, $sformatf("Unmapped port %h", p));
        end

        // 5: timer expiry with the line unmasked
        io_access(`PORT_IRQ_MASK, 1'b1, 16'h0000, rd);
        n = $urandom_range(40, 4);
        io_access(`PORT_TIMER, 1'b1, data_t'(n), rd);
        start = cycles;
        io_access(`PORT_TIMER, 1'b0, '0, rd);
        if (rd > data_t'(n)) mismatch($sformatf("Timer read %0d above loaded %0d", rd, n));
        intr_within(start, n + 4, "of the timer write");
        io_access(`PORT_IRQ_PEND, 1'b0, '0, rd);
        vec_ok(irq_vec_t'(rd[7:0]), 8'h01, "Pending after expiry");
        io_access(`PORT_IRQ_PEND, 1'b1, 16'h0001, rd);
        io_access(`PORT_IRQ_PEND, 1'b0, '0, rd);
        vec_ok(irq_vec_t'(rd[7:0]), 8'h00, "Pending after clear");
        @(negedge clk);
        level_ok(intr, 1'b0, "intr after clear");

        // 6: expiry while masked
        io_access(`PORT_IRQ_MASK, 1'b1, 16'h0001, rd);
        io_access(`PORT_IRQ_MASK, 1'b0, '0, rd);
        vec_ok(irq_vec_t'(rd[7:0]), 8'h01, "Mask readback");
        n = $urandom_range(40, 4);
        io_access(`PORT_TIMER, 1'b1, data_t'(n), rd);
        repeat (n + 4) begin
            @(negedge clk);
            level_ok(intr, 1'b0, "intr while masked");
        end
        io_access(`PORT_IRQ_PEND, 1'b0, '0, rd);
        vec_ok(irq_vec_t'(rd[7:0]), 8'h01, "Pending while masked");
        io_access(`PORT_IRQ_MASK, 1'b1, 16'h0000, rd);
        start = cycles;
        intr_within(start, 4, "of unmasking");
        io_access(`PORT_IRQ_PEND, 1'b1, 16'h0001, rd);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_access,
    input  soc_pkg::word_addr_t instr_addr,
    output logic                instr_ack,
    output soc_pkg::data_t      instr_rdata,
    input  logic                data_access,
    input  soc_pkg::data_req_t  data_req,
    output logic                data_ack,
    output soc_pkg::data_t      data_rdata,
    output logic                intr
);
    import soc_pkg::*;

    mem_req_t q_req;
    data_t    mem_data_rdata;
    data_t    io_rdata;
    data_t    q_rdata;
    data_t    timer_rdata;
    data_t    irq_rdata;
    data_t    ram_rdata;
    data_t    bios_rdata;
    irq_vec_t irq_in;
    logic     mem_data_access;
    logic     mem_data_ack;
    logic     io_ack;
    logic     q_access;
    logic     q_ack;
    logic     timer_sel;
    logic     irq_sel;
    logic     ram_sel;
    logic     bios_sel;
    logic     timer_ack;
    logic     irq_ack;
    logic     ram_ack;
    logic     bios_ack;
    logic     timer_expired;

    assign mem_data_access = data_access && !data_req.io;
    assign irq_in          = {7'b0, timer_expired};

    assign data_ack   = io_ack | mem_data_ack;
    assign data_rdata = io_ack ? io_rdata : mem_data_rdata;

    mem_arbiter i_mem_arbiter (
        .clk(clk), .rst(rst),
        .instr_access(instr_access), .instr_addr(instr_addr),
        .instr_ack(instr_ack), .instr_rdata(instr_rdata),
        .data_access(mem_data_access), .data_req(data_req.req),
        .data_ack(mem_data_ack), .data_rdata(mem_data_rdata),
        .q_access(q_access), .q_req(q_req), .q_ack(q_ack), .q_rdata(q_rdata)
    );

    bus_decoder i_bus_decoder (
        .clk(clk), .rst(rst),
        .data_access(data_access), .data_req(data_req),
        .io_ack(io_ack), .io_rdata(io_rdata),
        .timer_sel(timer_sel), .irq_sel(irq_sel), .ram_sel(ram_sel), .bios_sel(bios_sel),
        .timer_rdata(timer_rdata), .irq_rdata(irq_rdata),
        .ram_rdata(ram_rdata), .bios_rdata(bios_rdata),
        .timer_ack(timer_ack), .irq_ack(irq_ack), .ram_ack(ram_ack), .bios_ack(bios_ack),
        .q_access(q_access), .q_req(q_req), .q_ack(q_ack), .q_rdata(q_rdata)
    );

    bios_rom i_bios_rom (
        .clk(clk), .rst(rst), .sel(bios_sel), .addr(q_req.addr),
        .rdata(bios_rdata), .ack(bios_ack)
    );

    ram i_ram (
        .clk(clk), .rst(rst), .sel(ram_sel), .req(q_req),
        .rdata(ram_rdata), .ack(ram_ack)
    );

    timer i_timer (
        .clk(clk), .rst(rst), .sel(timer_sel), .req(data_req),
        .rdata(timer_rdata), .ack(timer_ack), .expired(timer_expired)
    );

    irq_controller i_irq_controller (
        .clk(clk), .rst(rst), .sel(irq_sel), .req(data_req), .irq_in(irq_in),
        .rdata(irq_rdata), .ack(irq_ack), .intr(intr)
    );

endmodule

`default_nettype wire

// File: timer.sv
`timescale 1ns/1ps
`default_nettype none

module timer (
    input  logic               clk,
    input  logic               rst,
    input  logic               sel,
    input  soc_pkg::data_req_t req,
    output soc_pkg::data_t     rdata,
    output logic               ack,
    output logic               expired
);
    import soc_pkg::*;

    data_t count;
    logic  load;

    // Only the first cycle of an access loads
    assign load = sel && !ack && req.req.wr_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            count   <= '0;
            ack     <= 1'b0;
            expired <= 1'b0;
        end else begin
            ack     <= sel && !ack;
            expired <= 1'b0;
            if (load) begin
                count <= req.req.wdata;
            end else if (count != '0) begin
                count   <= count - 16'd1;
                expired <= (count == 16'd1); // Step to zero
            end
        end
    end

    assign rdata = ack ? count : '0;

endmodule

`default_nettype wire
